/* hdl/rv_core_pkg.sv */
package rv_core_pkg;

   localparam int xlen = 32;

   typedef logic [4:0]      reg_addr_t;
   typedef logic [xlen-1:0] word_t;

   // 32-bit instruction formats with the opcode in the low seven bits
   typedef struct packed {
      logic [6:0] funct7;
      reg_addr_t  rs2;
      reg_addr_t  rs1;
      logic [2:0] funct3;
      reg_addr_t  rd;
      logic [6:0] opcode;
   } r_type_t;

   typedef struct packed {
      logic [11:0] imm;
      reg_addr_t   rs1;
      logic [2:0]  funct3;
      reg_addr_t   rd;
      logic [6:0]  opcode;
   } i_type_t;

   typedef struct packed {
      logic [6:0] imm_hi;
      reg_addr_t  rs2;
      reg_addr_t  rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
   } s_type_t;

   typedef struct packed {
      logic [19:0] imm;
      reg_addr_t   rd;
      logic [6:0]  opcode;
   } u_type_t;

   typedef union packed {
      r_type_t r;
      i_type_t i;
      s_type_t s;
      u_type_t u;
   } inst_t;

   typedef enum logic [1:0] {
      mem_byte = 2'd0,
      mem_half = 2'd1,
      mem_word = 2'd2
   } mem_size_t;

   typedef enum logic [3:0] {
      alu_add,
      alu_sub,
      alu_sll,
      alu_slt,
      alu_sltu,
      alu_xor,
      alu_srl,
      alu_sra,
      alu_or,
      alu_and
   } alu_op_t;

   typedef enum logic {
      wb_alu = 1'b0,
      wb_mem = 1'b1
   } wb_src_t;

   typedef struct packed {
      reg_addr_t rs1;
      reg_addr_t rs2;
      reg_addr_t rd;
      logic      reg_write;
      alu_op_t   alu_op;
      logic      src_b_imm;
      word_t     imm;
      logic      is_load;
      logic      is_store;
      mem_size_t mem_size;
      logic      load_unsigned;
      wb_src_t   wb_src;
   } dx_ctrl_t;

   typedef struct packed {
      logic      en;
      logic      wen;
      mem_size_t size;
      word_t     addr;
   } dmem_req_t;

   localparam word_t nop_inst = 32'h0000_0013; // addi x0,x0,0

endpackage

/* hdl/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu (
   input  rv_core_pkg::alu_op_t op,
   input  rv_core_pkg::word_t   in1,
   input  rv_core_pkg::word_t   in2,
   output rv_core_pkg::word_t   result
);

   logic [4:0] shamt;

   assign shamt = in2[4:0];

   always_comb begin
      case (op)
         rv_core_pkg::alu_add:  result = in1 + in2;
         rv_core_pkg::alu_sub:  result = in1 - in2;
         rv_core_pkg::alu_sll:  result = in1 << shamt;
         rv_core_pkg::alu_slt:  result = ($signed(in1) < $signed(in2)) ? 32'd1 : 32'd0;
         rv_core_pkg::alu_sltu: result = (in1 < in2) ? 32'd1 : 32'd0;
         rv_core_pkg::alu_xor:  result = in1 ^ in2;
         rv_core_pkg::alu_srl:  result = in1 >> shamt;
         rv_core_pkg::alu_sra:  result = $signed(in1) >>> shamt;
         rv_core_pkg::alu_or:   result = in1 | in2;
         rv_core_pkg::alu_and:  result = in1 & in2;
         default:               result = '0;
      endcase
   end

endmodule

/* hdl/rv_decoder.sv */
`timescale 1ns/1ps

module rv_decoder (
   input  rv_core_pkg::inst_t    inst,
   output rv_core_pkg::dx_ctrl_t ctrl
);

   localparam logic [6:0] op_lui   = 7'b0110111;
   localparam logic [6:0] op_imm   = 7'b0010011;
   localparam logic [6:0] op_reg   = 7'b0110011;
   localparam logic [6:0] op_load  = 7'b0000011;
   localparam logic [6:0] op_store = 7'b0100011;

   rv_core_pkg::word_t imm_i;
   rv_core_pkg::word_t imm_s;
   rv_core_pkg::word_t imm_u;

   assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
   assign imm_s = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
   assign imm_u = {inst.u.imm, 12'b0};

   // alt selects sub or sra
   function automatic rv_core_pkg::alu_op_t alu_func(input logic [2:0] funct3,
                                                     input logic       alt);
      case (funct3)
         3'b000:  alu_func = alt ? rv_core_pkg::alu_sub : rv_core_pkg::alu_add;
         3'b001:  alu_func = rv_core_pkg::alu_sll;
         3'b010:  alu_func = rv_core_pkg::alu_slt;
         3'b011:  alu_func = rv_core_pkg::alu_sltu;
         3'b100:  alu_func = rv_core_pkg::alu_xor;
         3'b101:  alu_func = alt ? rv_core_pkg::alu_sra : rv_core_pkg::alu_srl;
         3'b110:  alu_func = rv_core_pkg::alu_or;
         default: alu_func = rv_core_pkg::alu_and;
      endcase
   endfunction

   always_comb begin
      ctrl          = '0; // unknown opcodes fall through as no-ops
      ctrl.alu_op   = rv_core_pkg::alu_add;
      ctrl.mem_size = rv_core_pkg::mem_word;
      ctrl.wb_src   = rv_core_pkg::wb_alu;
      case (inst.r.opcode)
         op_lui: begin
            ctrl.rd        = inst.u.rd; // rs1 stays x0, so add passes imm
            ctrl.reg_write = 1'b1;
            ctrl.src_b_imm = 1'b1;
            ctrl.imm       = imm_u;
         end
         op_imm: begin
            ctrl.rs1       = inst.i.rs1;
            ctrl.rd        = inst.i.rd;
            ctrl.reg_write = 1'b1;
            ctrl.src_b_imm = 1'b1;
            ctrl.imm       = imm_i;
            // only srai uses bit 30, addi has no subtract form
            ctrl.alu_op    = alu_func(inst.i.funct3,
                                      inst.r.funct7[5] && inst.i.funct3 == 3'b101);
         end
         op_reg: begin
            ctrl.rs1       = inst.r.rs1;
            ctrl.rs2       = inst.r.rs2;
            ctrl.rd        = inst.r.rd;
            ctrl.reg_write = 1'b1;
            ctrl.alu_op    = alu_func(inst.r.funct3, inst.r.funct7[5]);
         end
         op_load: begin
            ctrl.rs1           = inst.i.rs1;
            ctrl.rd            = inst.i.rd;
            ctrl.reg_write     = 1'b1;
            ctrl.src_b_imm     = 1'b1;
            ctrl.imm           = imm_i;
            ctrl.is_load       = 1'b1;
            ctrl.mem_size      = rv_core_pkg::mem_size_t'(inst.i.funct3[1:0]);
            ctrl.load_unsigned = inst.i.funct3[2];
            ctrl.wb_src        = rv_core_pkg::wb_mem;
         end
         op_store: begin
            ctrl.rs1       = inst.s.rs1;
            ctrl.rs2       = inst.s.rs2;
            ctrl.src_b_imm = 1'b1;
            ctrl.imm       = imm_s;
            ctrl.is_store  = 1'b1;
            ctrl.mem_size  = rv_core_pkg::mem_size_t'(inst.s.funct3[1:0]);
         end
         default: begin
         end
      endcase
   end

endmodule

/* hdl/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile (
   input  logic                   clk,
   input  rv_core_pkg::reg_addr_t ra1,
   input  rv_core_pkg::reg_addr_t ra2,
   output rv_core_pkg::word_t     rd1,
   output rv_core_pkg::word_t     rd2,
   input  logic                   wen,
   input  rv_core_pkg::reg_addr_t wa,
   input  rv_core_pkg::word_t     wd,
   input  logic                   debug_read,
   input  logic                   debug_write,
   input  rv_core_pkg::reg_addr_t debug_addr,
   input  rv_core_pkg::word_t     debug_wdata
);

   rv_core_pkg::word_t     regs [1:31]; // x0 is not stored
   rv_core_pkg::reg_addr_t addr1;
   rv_core_pkg::reg_addr_t waddr;
   rv_core_pkg::word_t     wdata;
   logic                   wr;

   // debug takes over read port 1 and the write port
   assign addr1 = debug_read ? debug_addr : ra1;
   assign wr    = debug_write | wen;
   assign waddr = debug_write ? debug_addr : wa;
   assign wdata = debug_write ? debug_wdata : wd;

   always_ff @(posedge clk) begin
      if (wr && waddr != '0) begin
         regs[waddr] <= wdata;
      end
   end

   assign rd1 = (addr1 == '0) ? '0 : regs[addr1];
   assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

/* hdl/rv_mem_align.sv */
`timescale 1ns/1ps

module rv_mem_align (
   input  rv_core_pkg::mem_size_t size,
   input  logic                   load_unsigned,
   input  logic [1:0]             addr_low,
   input  rv_core_pkg::word_t     rdata,
   input  rv_core_pkg::word_t     store_in,
   output rv_core_pkg::word_t     load_out,
   output rv_core_pkg::word_t     store_out
);

   rv_core_pkg::word_t shifted;

   assign shifted = rdata >> {addr_low, 3'b000}; // addressed lane down to bit 0

   always_comb begin
      case (size)
         rv_core_pkg::mem_byte: begin
            load_out = load_unsigned ? {24'b0, shifted[7:0]}
                                     : {{24{shifted[7]}}, shifted[7:0]};
         end
         rv_core_pkg::mem_half: begin
            load_out = load_unsigned ? {16'b0, shifted[15:0]}
                                     : {{16{shifted[15]}}, shifted[15:0]};
         end
         default: load_out = shifted;
      endcase
   end

   // memory picks the lane by address
   always_comb begin
      case (size)
         rv_core_pkg::mem_byte: store_out = {4{store_in[7:0]}};
         rv_core_pkg::mem_half: store_out = {2{store_in[15:0]}};
         default:               store_out = store_in;
      endcase
   end

endmodule

/* hdl/rv_core.sv */
`timescale 1ns/1ps

module rv_core #(
   parameter rv_core_pkg::word_t RESET_PC = 32'h0000_0200
) (
   input  logic                   clk,
   input  logic                   reset,
   output rv_core_pkg::word_t     imem_addr,
   input  rv_core_pkg::word_t     imem_rdata,
   input  logic                   imem_wait,
   output rv_core_pkg::dmem_req_t dmem_req,
   output rv_core_pkg::word_t     dmem_wdata,
   input  rv_core_pkg::word_t     dmem_rdata,
   input  logic                   dmem_wait,
   input  logic                   haltreq,
   input  logic                   resumereq,
   output logic                   halted,
   input  logic                   debug_read,
   input  logic                   debug_write,
   input  rv_core_pkg::reg_addr_t debug_reg_index,
   input  rv_core_pkg::word_t     debug_wdata,
   output rv_core_pkg::word_t     debug_rdata
);

   typedef enum logic [1:0] {
      st_running,
      st_draining,
      st_halted
   } halt_state_t;

   halt_state_t state;
   logic        stall;
   logic        running;
   logic        halt_now;
   logic        take;

   rv_core_pkg::word_t pc_f; // address on imem_addr
   rv_core_pkg::word_t held_pc;
   logic               if_valid; // imem_rdata holds a requested word
   logic               dx_valid;
   logic               wb_valid;

   rv_core_pkg::inst_t    inst_dx;
   rv_core_pkg::dx_ctrl_t ctrl;
   rv_core_pkg::word_t    rs1_data;
   rv_core_pkg::word_t    rs2_data;
   rv_core_pkg::word_t    rs1_byp;
   rv_core_pkg::word_t    rs2_byp;
   rv_core_pkg::word_t    alu_in2;
   rv_core_pkg::word_t    alu_out;
   logic                  bypass_rs1;
   logic                  bypass_rs2;

   rv_core_pkg::word_t     wb_alu;
   rv_core_pkg::word_t     wb_store_data;
   rv_core_pkg::reg_addr_t wb_rd;
   logic                   wb_reg_write;
   rv_core_pkg::mem_size_t wb_size;
   logic                   wb_load_unsigned;
   rv_core_pkg::wb_src_t   wb_src;
   rv_core_pkg::word_t     load_word;
   rv_core_pkg::word_t     wb_result;
   logic                   rf_wen;
   logic                   dbg_read;
   logic                   dbg_write;

   assign stall    = imem_wait | dmem_wait;
   assign running  = state == st_running;
   assign halt_now = running & haltreq;
   assign take     = running & ~haltreq & if_valid;
   assign held_pc  = if_valid ? pc_f - 32'd4 : pc_f; // word on imem_rdata gets dropped
   assign imem_addr = pc_f;
   assign halted   = state == st_halted;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= st_running;
      end else begin
         case (state)
            st_running:  if (!stall && haltreq) state <= st_draining;
            st_draining: if (!dx_valid && !wb_valid) state <= st_halted;
            st_halted:   if (resumereq) state <= st_running;
            default:     state <= st_running;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pc_f     <= RESET_PC;
         if_valid <= 1'b0;
         inst_dx  <= rv_core_pkg::nop_inst;
         dx_valid <= 1'b0;
      end else if (!stall) begin
         if (halt_now) begin
            pc_f     <= held_pc;
            if_valid <= 1'b0;
         end else if (running) begin
            pc_f     <= pc_f + 32'd4;
            if_valid <= 1'b1;
         end
         inst_dx  <= take ? imem_rdata : rv_core_pkg::nop_inst;
         dx_valid <= take;
      end
   end

   rv_decoder u_rv_decoder (
      .inst (inst_dx),
      .ctrl (ctrl)
   );

   assign dbg_read  = debug_read & halted;
   assign dbg_write = debug_write & halted;
   assign rf_wen    = wb_reg_write & ~stall; // last wb cycle is always unstalled

   rv_regfile u_rv_regfile (
      .clk         (clk),
      .ra1         (ctrl.rs1),
      .ra2         (ctrl.rs2),
      .rd1         (rs1_data),
      .rd2         (rs2_data),
      .wen         (rf_wen),
      .wa          (wb_rd),
      .wd          (wb_result),
      .debug_read  (dbg_read),
      .debug_write (dbg_write),
      .debug_addr  (debug_reg_index),
      .debug_wdata (debug_wdata)
   );

   assign debug_rdata = dbg_read ? rs1_data : '0;

   // wb result goes back to decode, even for loads
   assign bypass_rs1 = wb_reg_write && wb_rd != '0 && wb_rd == ctrl.rs1;
   assign bypass_rs2 = wb_reg_write && wb_rd != '0 && wb_rd == ctrl.rs2;
   assign rs1_byp    = bypass_rs1 ? wb_result : rs1_data;
   assign rs2_byp    = bypass_rs2 ? wb_result : rs2_data;
   assign alu_in2    = ctrl.src_b_imm ? ctrl.imm : rs2_byp;

   rv_alu u_rv_alu (
      .op     (ctrl.alu_op),
      .in1    (rs1_byp),
      .in2    (alu_in2),
      .result (alu_out)
   );

   always_comb begin
      dmem_req.en   = ctrl.is_load | ctrl.is_store;
      dmem_req.wen  = ctrl.is_store;
      dmem_req.size = ctrl.mem_size;
      // debug reads steer alu_out while halted
      dmem_req.addr = (ctrl.is_load | ctrl.is_store) ? alu_out : '0;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wb_reg_write <= 1'b0;
         wb_valid     <= 1'b0;
      end else if (!stall) begin
         wb_reg_write <= ctrl.reg_write;
         wb_valid     <= dx_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         wb_alu           <= alu_out;
         wb_store_data    <= rs2_byp;
         wb_rd            <= ctrl.rd;
         wb_size          <= ctrl.mem_size;
         wb_load_unsigned <= ctrl.load_unsigned;
         wb_src           <= ctrl.wb_src;
      end
   end

   rv_mem_align u_rv_mem_align (
      .size          (wb_size),
      .load_unsigned (wb_load_unsigned),
      .addr_low      (wb_alu[1:0]),
      .rdata         (dmem_rdata),
      .store_in      (wb_store_data),
      .load_out      (load_word),
      .store_out     (dmem_wdata)
   );

   assign wb_result = (wb_src == rv_core_pkg::wb_mem) ? load_word : wb_alu;

endmodule

/* sim/rv_core_properties.sv */
`timescale 1ns/1ps

module rv_core_properties (
   input logic                   clk,
   input logic                   reset,
   input rv_core_pkg::dmem_req_t dmem_req,
   input logic                   dmem_wait,
   input logic                   halted,
   input logic                   debug_write
);

   no_req_halted: assert property (@(posedge clk) disable iff (reset) halted |-> !dmem_req.en)
      else $error("data request while halted");

   // request must hold through a data wait
   req_stable: assert property (@(posedge clk) disable iff (reset)
                                dmem_wait |=> $stable(dmem_req))
      else $error("dmem_req changed during dmem_wait");

   dbg_write_halted: assert property (@(posedge clk) disable iff (reset)
                                      debug_write |-> halted)
      else $error("debug_write while running");

   reset_quiet: assert property (@(posedge clk) reset |=> !dmem_req.en && !halted)
      else $error("request or halted active after reset");

endmodule

bind rv_core rv_core_properties u_rv_core_properties (
   .clk         (clk),
   .reset       (reset),
   .dmem_req    (dmem_req),
   .dmem_wait   (dmem_wait),
   .halted      (halted),
   .debug_write (debug_write)
);

/* sim/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb;

   localparam rv_core_pkg::word_t reset_pc  = 32'h0000_0200;
   localparam rv_core_pkg::word_t data_base = 32'h0001_0000;
   localparam int                 prog_len  = 61;

   logic                   clk;
   logic                   reset;
   rv_core_pkg::word_t     imem_addr;
   rv_core_pkg::word_t     imem_rdata;
   logic                   imem_wait;
   rv_core_pkg::dmem_req_t dmem_req;
   rv_core_pkg::word_t     dmem_wdata;
   rv_core_pkg::word_t     dmem_rdata;
   logic                   dmem_wait;
   logic                   haltreq;
   logic                   resumereq;
   logic                   halted;
   logic                   debug_read;
   logic                   debug_write;
   rv_core_pkg::reg_addr_t debug_reg_index;
   rv_core_pkg::word_t     debug_wdata;
   rv_core_pkg::word_t     debug_rdata;

   rv_core_pkg::word_t     prog [prog_len];
   rv_core_pkg::word_t     ref_regs [32];
   rv_core_pkg::word_t     ref_mem [rv_core_pkg::word_t];
   rv_core_pkg::word_t     dut_mem [rv_core_pkg::word_t];
   rv_core_pkg::dmem_req_t exp_req [$];
   rv_core_pkg::word_t     exp_wdata [$];
   int                     errors;
   int                     timeouts;
   int                     checks;
   rv_core_pkg::word_t     next_irdata;
   rv_core_pkg::word_t     next_drdata;
   logic                   st_pend;
   rv_core_pkg::dmem_req_t st_req;
   rv_core_pkg::word_t     st_mask;

   rv_core #(.RESET_PC(reset_pc)) u_rv_core (
      .clk             (clk),
      .reset           (reset),
      .imem_addr       (imem_addr),
      .imem_rdata      (imem_rdata),
      .imem_wait       (imem_wait),
      .dmem_req        (dmem_req),
      .dmem_wdata      (dmem_wdata),
      .dmem_rdata      (dmem_rdata),
      .dmem_wait       (dmem_wait),
      .haltreq         (haltreq),
      .resumereq       (resumereq),
      .halted          (halted),
      .debug_read      (debug_read),
      .debug_write     (debug_write),
      .debug_reg_index (debug_reg_index),
      .debug_wdata     (debug_wdata),
      .debug_rdata     (debug_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic rv_core_pkg::word_t read_word(input bit use_ref,
                                                    input rv_core_pkg::word_t widx);
      if (use_ref && ref_mem.exists(widx)) return ref_mem[widx];
      if (!use_ref && dut_mem.exists(widx)) return dut_mem[widx];
      return ({widx[29:0], 2'b00} * 32'h9e37_79b9) ^ 32'h0ff1_c0de; // unwritten data
   endfunction

   function automatic rv_core_pkg::word_t lane_mask(input rv_core_pkg::mem_size_t size,
                                                    input logic [1:0] off);
      case (size)
         rv_core_pkg::mem_byte: return 32'h0000_00ff << {off, 3'b000};
         rv_core_pkg::mem_half: return 32'h0000_ffff << {off, 3'b000};
         default:               return 32'hffff_ffff;
      endcase
   endfunction

   function automatic rv_core_pkg::word_t ref_alu(input logic [2:0] f3, input logic alt,
                                                  input rv_core_pkg::word_t x,
                                                  input rv_core_pkg::word_t y);
      case (f3)
         3'd0: return alt ? x - y : x + y;
         3'd1: return x << y[4:0];
         3'd2: return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
         3'd3: return (x < y) ? 32'd1 : 32'd0;
         3'd4: return x ^ y;
         3'd5: begin
            if (alt) return rv_core_pkg::word_t'($signed(x) >>> y[4:0]);
            return x >> y[4:0];
         end
         3'd6: return x | y;
         default: return x & y;
      endcase
   endfunction

   // one instruction of the ISA against the model state
   function automatic void exec(input rv_core_pkg::word_t inst);
      rv_core_pkg::word_t     a;
      rv_core_pkg::word_t     b;
      rv_core_pkg::word_t     immi;
      rv_core_pkg::word_t     addr;
      rv_core_pkg::word_t     sh;
      rv_core_pkg::word_t     res;
      rv_core_pkg::word_t     rep;
      rv_core_pkg::word_t     mask;
      rv_core_pkg::dmem_req_t req;
      logic [2:0]             f3;
      logic                   wr;
      a    = ref_regs[inst[19:15]];
      b    = ref_regs[inst[24:20]];
      f3   = inst[14:12];
      immi = {{20{inst[31]}}, inst[31:20]};
      res  = '0;
      wr   = 1'b1;
      case (inst[6:0])
         7'h37: res = {inst[31:12], 12'h000};
         7'h13: res = ref_alu(f3, f3 == 3'd5 && inst[30], a, immi);
         7'h33: res = ref_alu(f3, inst[30], a, b);
         7'h03: begin
            addr = a + immi;
            sh   = read_word(1'b1, addr >> 2) >> {addr[1:0], 3'b000};
            case (f3)
               3'd0:    res = {{24{sh[7]}}, sh[7:0]};
               3'd1:    res = {{16{sh[15]}}, sh[15:0]};
               3'd4:    res = {24'h0, sh[7:0]};
               3'd5:    res = {16'h0, sh[15:0]};
               default: res = sh;
            endcase
         end
         7'h23: begin
            wr       = 1'b0;
            addr     = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
            req.en   = 1'b1;
            req.wen  = 1'b1;
            req.size = rv_core_pkg::mem_size_t'(f3[1:0]);
            req.addr = addr;
            case (f3[1:0])
               2'd0:    rep = {4{b[7:0]}};
               2'd1:    rep = {2{b[15:0]}};
               default: rep = b;
            endcase
            mask = lane_mask(req.size, addr[1:0]);
            ref_mem[addr >> 2] = (read_word(1'b1, addr >> 2) & ~mask) | (rep & mask);
            exp_req.push_back(req);
            exp_wdata.push_back(rep);
         end
         default: wr = 1'b0;
      endcase
      if (wr && inst[11:7] != 5'd0) ref_regs[inst[11:7]] = res;
   endfunction

   function automatic rv_core_pkg::word_t rand_inst(input rv_core_pkg::reg_addr_t prev_rd);
      rv_core_pkg::reg_addr_t rd;
      rv_core_pkg::reg_addr_t rs1;
      rv_core_pkg::reg_addr_t rs2;
      logic [2:0]             f3;
      logic                   alt;
      logic [11:0]            imm;
      logic [1:0]             sz;
      rd  = rv_core_pkg::reg_addr_t'(2 + $urandom % 30); // x1 stays the data base
      rs1 = ($urandom % 2 == 0) ? prev_rd : rv_core_pkg::reg_addr_t'($urandom);
      rs2 = ($urandom % 3 == 0) ? prev_rd : rv_core_pkg::reg_addr_t'($urandom);
      f3  = 3'($urandom);
      alt = 1'($urandom);
      sz  = 2'($urandom % 3);
      imm = 12'($urandom);
      case ($urandom % 5)
         0: return {20'($urandom), rd, 7'h37};
         1: begin
            if (f3 == 3'd1) imm = {7'h00, rs2};
            else if (f3 == 3'd5) imm = {alt ? 7'h20 : 7'h00, rs2};
            return {imm, rs1, f3, rd, 7'h13};
         end
         2: return {(alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'h33};
         3: begin
            imm = 12'(($urandom % 64) << sz); // naturally aligned
            return {imm, 5'd1, sz != 2'd2 && alt, sz, rd, 7'h03};
         end
         default: begin
            imm = 12'(($urandom % 64) << sz);
            return {imm[11:5], rs2, 5'd1, 1'b0, sz, imm[4:0], 7'h23};
         end
      endcase
   endfunction

   task automatic compare_word(input rv_core_pkg::word_t got, input rv_core_pkg::word_t exp,
                               input string name);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_req(input rv_core_pkg::dmem_req_t got,
                            input rv_core_pkg::dmem_req_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at %0t: dmem_req got %h expected %h", $time, got, exp);
      end
   endtask

   task automatic verify_reg(input rv_core_pkg::reg_addr_t idx, input rv_core_pkg::word_t got,
                             input rv_core_pkg::word_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at %0t: x%0d got %h expected %h", $time, idx, got, exp);
      end
   endtask

   // fetch and data words arrive one cycle after an unstalled request
   always @(posedge clk) begin
      if (!reset && !imem_wait && !dmem_wait) begin
         if (st_pend) begin
            st_mask = lane_mask(st_req.size, st_req.addr[1:0]);
            dut_mem[st_req.addr >> 2] = (read_word(1'b0, st_req.addr >> 2) & ~st_mask)
                                        | (dmem_wdata & st_mask);
            if (exp_req.size() == 0) begin
               errors++;
               $display("store to %h committed with no store left in the program", st_req.addr);
            end else begin
               check_req(st_req, exp_req.pop_front());
               compare_word(dmem_wdata, exp_wdata.pop_front(), "dmem_wdata");
            end
         end
         st_pend = dmem_req.en && dmem_req.wen;
         st_req  = dmem_req;
         if (dmem_req.en && !dmem_req.wen) next_drdata = read_word(1'b0, dmem_req.addr >> 2);
         if (imem_addr >= reset_pc && ((imem_addr - reset_pc) >> 2) < prog_len)
            next_irdata = prog[(imem_addr - reset_pc) >> 2];
         else
            next_irdata = rv_core_pkg::nop_inst;
      end
   end

   always @(negedge clk) begin
      imem_rdata <= next_irdata;
      dmem_rdata <= next_drdata;
      imem_wait  <= ($urandom % 4) == 0;
      dmem_wait  <= ($urandom % 4) == 0;
   end

   task automatic wait_halted(input string what);
      int n;
      n = 0;
      while (!halted && n < 500) begin
         @(negedge clk);
         n++;
      end
      if (!halted) begin
         timeouts++;
         $display("timed out waiting for the core to halt %s", what);
      end
   endtask

   task automatic resume_core();
      haltreq   = 1'b0;
      resumereq = 1'b1;
      @(negedge clk);
      resumereq = 1'b0;
   endtask

   task automatic poke_gpr(input rv_core_pkg::reg_addr_t idx, input rv_core_pkg::word_t val);
      debug_write     = 1'b1;
      debug_reg_index = idx;
      debug_wdata     = val;
      @(negedge clk);
      debug_write = 1'b0;
   endtask

   task automatic peek_gpr(input rv_core_pkg::reg_addr_t idx, output rv_core_pkg::word_t val);
      debug_read      = 1'b1;
      debug_reg_index = idx;
      @(posedge clk);
      val = debug_rdata;
      @(negedge clk);
      debug_read = 1'b0;
   endtask

   initial begin
      int                     n;
      rv_core_pkg::reg_addr_t prev;
      rv_core_pkg::word_t     got;
      void'($urandom(32'h7551_0ff1));
      {reset, haltreq, resumereq, debug_read, debug_write} = 5'b11000;
      {imem_wait, dmem_wait, st_pend} = 3'b000;
      {imem_rdata, dmem_rdata, debug_wdata, debug_reg_index} = '0;
      next_irdata = rv_core_pkg::nop_inst;
      next_drdata = '0;
      errors = 0;
      timeouts = 0;
      checks = 0;
      prog[0] = {data_base[31:12], 5'd1, 7'h37};
      prev = 5'd1;
      for (int i = 1; i < prog_len; i++) begin
         prog[i] = rand_inst(prev);
         prev = prog[i][11:7]; // next one often reads it
      end
      repeat (8) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      wait_halted("after reset");
      compare_word(imem_addr, reset_pc, "imem_addr");
      ref_regs[0] = '0;
      ref_regs[1] = '0;
      for (int i = 2; i < 32; i++) begin
         ref_regs[i] = $urandom;
         poke_gpr(rv_core_pkg::reg_addr_t'(i), ref_regs[i]);
      end
      for (int i = 0; i < 32; i++) begin
         if (i != 1) begin
            peek_gpr(rv_core_pkg::reg_addr_t'(i), got);
            verify_reg(rv_core_pkg::reg_addr_t'(i), got, ref_regs[i]);
         end
      end
      for (int i = 0; i < prog_len; i++) exec(prog[i]);
      resume_core();
      repeat (20 + $urandom % 30) @(negedge clk);
      haltreq = 1'b1; // mid-program halt
      wait_halted("in mid-program");
      resume_core();
      n = 0;
      while (imem_addr < reset_pc + 4 * (prog_len + 4) && n < 2000) begin
         @(negedge clk);
         n++;
      end
      if (n >= 2000) begin
         timeouts++;
         $display("timed out waiting for fetch to pass the program end");
      end
      haltreq = 1'b1;
      wait_halted("at program end");
      for (int i = 0; i < 32; i++) begin
         peek_gpr(rv_core_pkg::reg_addr_t'(i), got);
         verify_reg(rv_core_pkg::reg_addr_t'(i), got, ref_regs[i]);
      end
      if (exp_req.size() != 0) begin
         errors++;
         $display("%0d stores of the program never committed", exp_req.size());
      end
      $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* files.f */
hdl/rv_core_pkg.sv
hdl/rv_alu.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_mem_align.sv
hdl/rv_core.sv
sim/rv_core_properties.sv
sim/rv_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module rv_core_tb \
   -f files.f -o rv_core_sim > build.log 2>&1 &&
./obj_dir/rv_core_sim > sim.log 2>&1 ;
cat sim.log ;
grep -q "^Simulation passed$" sim.log && echo "run ok" || { echo "run failed, see sim.log and build.log"; exit 1; }
